/* common/frontend_config.svh */
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// fetch address and block geometry
`define ADDR_W       32
`define BLOCK_BYTES  32
`define BLOCK_SHIFT  5

// target buffer index sits just above the block offset
`define BTB_IDX_W    6

// global history and predictor tables
`define GHT_W        8
`define PRED_IDX_W   8

// return stack
`define RAS_DEPTH    8
`define RAS_PTR_W    3

`define RESET_IP     32'h0000_1000

// branch kinds as stored in the target buffer
`define KIND_COND    2'd0
`define KIND_JUMP    2'd1
`define KIND_CALL    2'd2
`define KIND_RET     2'd3

`endif

/* common/frontend_pkg.sv */
`include "frontend_config.svh"

package frontend_pkg;

  // fetch block or branch target address
  typedef logic [`ADDR_W-1:0] addr_t;

  // global branch history, newest outcome in bit 0
  typedef logic [`GHT_W-1:0] ght_t;

  typedef logic [`BTB_IDX_W-1:0] btb_idx_t;

  typedef logic [1:0] br_kind_t;

  // one bit per branch slot of a fetch block
  typedef logic [1:0] slot_bits_t;

endpackage

/* predict/branch_target_buffer.sv */
`include "frontend_config.svh"

module branch_target_buffer (
  input  logic                     clk,
  input  logic                     rst,
  input  frontend_pkg::addr_t      fetch_ip,
  input  logic                     upd_valid,
  input  frontend_pkg::addr_t      upd_src_ip,
  input  logic                     upd_slot,
  input  frontend_pkg::addr_t      upd_target,
  input  frontend_pkg::br_kind_t   upd_kind,
  output frontend_pkg::slot_bits_t hit,
  output frontend_pkg::addr_t      target0,
  output frontend_pkg::addr_t      target1,
  output frontend_pkg::br_kind_t   kind0,
  output frontend_pkg::br_kind_t   kind1
);

  localparam int TAG_W = `ADDR_W - `BLOCK_SHIFT - `BTB_IDX_W;
  localparam int ENTRIES = 1 << `BTB_IDX_W;

  frontend_pkg::slot_bits_t valid_mem [ENTRIES];
  logic [TAG_W-1:0]         tag_mem [2][ENTRIES];
  frontend_pkg::addr_t      target_mem [2][ENTRIES];
  frontend_pkg::br_kind_t   kind_mem [2][ENTRIES];

  frontend_pkg::btb_idx_t rd_idx;
  frontend_pkg::btb_idx_t wr_idx;
  logic [TAG_W-1:0]       rd_tag;
  logic [TAG_W-1:0]       wr_tag;

  assign rd_idx = fetch_ip[`BLOCK_SHIFT +: `BTB_IDX_W];
  assign rd_tag = fetch_ip[`ADDR_W-1 -: TAG_W];
  assign wr_idx = upd_src_ip[`BLOCK_SHIFT +: `BTB_IDX_W];
  assign wr_tag = upd_src_ip[`ADDR_W-1 -: TAG_W];

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      hit[s] = valid_mem[rd_idx][s] && tag_mem[s][rd_idx] == rd_tag;
    end
  end

  assign target0 = target_mem[0][rd_idx];
  assign target1 = target_mem[1][rd_idx];
  assign kind0 = kind_mem[0][rd_idx];
  assign kind1 = kind_mem[1][rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) valid_mem[i] <= '0;
    end else if (upd_valid) begin
      valid_mem[wr_idx][upd_slot] <= 1'b1;
    end
  end

  // every retired branch rewrites its slot
  always_ff @(posedge clk) begin
    if (upd_valid) begin
      tag_mem[upd_slot][wr_idx] <= wr_tag;
      target_mem[upd_slot][wr_idx] <= upd_target;
      kind_mem[upd_slot][wr_idx] <= upd_kind;
    end
  end

  a_upd_aligned: assert property (@(posedge clk) disable iff (rst)
    upd_valid |-> upd_src_ip[`BLOCK_SHIFT-1:0] == '0);

endmodule

/* predict/hashed_predictor.sv */
`include "frontend_config.svh"

module hashed_predictor (
  input  logic                     clk,
  input  logic                     rst,
  input  frontend_pkg::addr_t      fetch_ip,
  input  frontend_pkg::ght_t       fetch_ght,
  input  logic                     upd_valid,
  input  logic                     upd_mispredict,
  input  frontend_pkg::addr_t      upd_src_ip,
  input  frontend_pkg::ght_t       upd_ght,
  input  logic                     upd_slot,
  output frontend_pkg::slot_bits_t pred
);

  localparam int ENTRIES = 1 << `PRED_IDX_W;

  frontend_pkg::slot_bits_t tab_a [ENTRIES];
  frontend_pkg::slot_bits_t tab_b [ENTRIES];
  frontend_pkg::slot_bits_t tab_c [ENTRIES];
  frontend_pkg::slot_bits_t flip_mask;
  logic [1:0]               rr; // table to flip next, 0..2

  // short history, mostly address
  function automatic logic [`PRED_IDX_W-1:0] hash_a(frontend_pkg::addr_t ip,
                                                    frontend_pkg::ght_t g);
    return {ip[`BLOCK_SHIFT +: 6], g[1:0]};
  endfunction

  // four address bits folded over six history bits
  function automatic logic [`PRED_IDX_W-1:0] hash_b(frontend_pkg::addr_t ip,
                                                    frontend_pkg::ght_t g);
    return {ip[`BLOCK_SHIFT +: 4], 4'b0000} ^ {2'b00, g[5:0]};
  endfunction

  // history heavy
  function automatic logic [`PRED_IDX_W-1:0] hash_c(frontend_pkg::addr_t ip,
                                                    frontend_pkg::ght_t g);
    return {ip[`BLOCK_SHIFT +: 2], g[`GHT_W-3:0]};
  endfunction

  assign pred = tab_a[hash_a(fetch_ip, fetch_ght)]
              ^ tab_b[hash_b(fetch_ip, fetch_ght)]
              ^ tab_c[hash_c(fetch_ip, fetch_ght)];

  assign flip_mask = upd_slot ? 2'b10 : 2'b01;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        tab_a[i] <= '0;
        tab_b[i] <= '0;
        tab_c[i] <= '0;
      end
      rr <= 2'd0;
    end else if (upd_valid && upd_mispredict) begin
      case (rr)
        2'd0: tab_a[hash_a(upd_src_ip, upd_ght)] <= tab_a[hash_a(upd_src_ip, upd_ght)] ^ flip_mask;
        2'd1: tab_b[hash_b(upd_src_ip, upd_ght)] <= tab_b[hash_b(upd_src_ip, upd_ght)] ^ flip_mask;
        default: tab_c[hash_c(upd_src_ip, upd_ght)] <= tab_c[hash_c(upd_src_ip, upd_ght)] ^ flip_mask;
      endcase
      rr <= (rr == 2'd2) ? 2'd0 : rr + 2'd1;
    end
  end

endmodule

/* predict/return_stack.sv */
`include "frontend_config.svh"

module return_stack (
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  frontend_pkg::addr_t push_addr,
  input  logic                pop,
  output frontend_pkg::addr_t ras_top
);

  frontend_pkg::addr_t     stack_mem [`RAS_DEPTH];
  logic [`RAS_PTR_W-1:0]   ptr; // points at the top entry
  logic [`RAS_PTR_W-1:0]   ptr_inc;

  assign ptr_inc = ptr + 1'b1; // wraps so the oldest entry gets overwritten
  assign ras_top = stack_mem[ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (push) begin
      ptr <= ptr_inc;
    end else if (pop) begin
      ptr <= ptr - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst && push) begin
      stack_mem[ptr_inc] <= push_addr;
    end
  end

  // the sequencer picks one of irq, call or return per block
  a_no_push_pop: assert property (@(posedge clk) disable iff (rst)
    !(push && pop));

endmodule

/* rtl/fetch_sequencer.sv */
`include "frontend_config.svh"

module fetch_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   hold,
  input  logic                   irq_valid,
  input  frontend_pkg::addr_t    irq_ip,
  input  logic                   upd_valid,
  input  frontend_pkg::addr_t    upd_src_ip,
  input  frontend_pkg::addr_t    upd_target,
  input  logic                   upd_taken,
  input  logic                   upd_mispredict,
  input  frontend_pkg::ght_t     upd_ght,
  input  frontend_pkg::slot_bits_t hit,
  input  frontend_pkg::slot_bits_t pred,
  input  frontend_pkg::addr_t    target0,
  input  frontend_pkg::addr_t    target1,
  input  frontend_pkg::br_kind_t kind0,
  input  frontend_pkg::br_kind_t kind1,
  input  frontend_pkg::addr_t    ras_top,
  output frontend_pkg::addr_t    fetch_ip,
  output frontend_pkg::ght_t     fetch_ght,
  output logic                   fetch_valid,
  output logic                   push,
  output frontend_pkg::addr_t    push_addr,
  output logic                   pop
);

  localparam frontend_pkg::addr_t BLOCK_STEP = `BLOCK_BYTES;

  frontend_pkg::addr_t seq_ip;
  frontend_pkg::addr_t pred_ip;
  frontend_pkg::addr_t next_ip;
  frontend_pkg::ght_t  pred_ght;
  frontend_pkg::ght_t  next_ght;
  logic                taken0;
  logic                taken1;
  logic                pred_call;
  logic                pred_ret;

  assign seq_ip = fetch_ip + BLOCK_STEP;

  // slot 0 wins when both slots are taken
  always_comb begin
    taken0 = hit[0] && (kind0 != `KIND_COND || pred[0]);
    taken1 = hit[1] && (kind1 != `KIND_COND || pred[1]);
    pred_ip = seq_ip;
    pred_ght = fetch_ght;
    pred_call = 1'b0;
    pred_ret = 1'b0;
    if (taken0) begin
      pred_ip = (kind0 == `KIND_RET) ? ras_top : target0;
      pred_ght = {fetch_ght[`GHT_W-2:0], 1'b1};
      pred_call = kind0 == `KIND_CALL;
      pred_ret = kind0 == `KIND_RET;
    end else if (taken1) begin
      pred_ip = (kind1 == `KIND_RET) ? ras_top : target1;
      pred_ght = hit[0] ? {fetch_ght[`GHT_W-3:0], 2'b01} : {fetch_ght[`GHT_W-2:0], 1'b1};
      pred_call = kind1 == `KIND_CALL;
      pred_ret = kind1 == `KIND_RET;
    end else if (&hit) begin
      pred_ght = {fetch_ght[`GHT_W-3:0], 2'b00};
    end else if (|hit) begin
      pred_ght = {fetch_ght[`GHT_W-2:0], 1'b0};
    end
  end

  always_comb begin
    next_ip = fetch_ip;
    next_ght = fetch_ght;
    push = 1'b0;
    pop = 1'b0;
    push_addr = seq_ip; // return point of a call
    if (upd_valid && upd_mispredict) begin
      next_ip = upd_taken ? upd_target : upd_src_ip + BLOCK_STEP;
      next_ght = {upd_ght[`GHT_W-2:0], upd_taken};
    end else if (irq_valid) begin
      next_ip = irq_ip;
      push = 1'b1;
      push_addr = fetch_ip; // resume the interrupted block
    end else if (fetch_valid && !hold) begin // first valid cycle shows the reset address
      next_ip = pred_ip;
      next_ght = pred_ght;
      push = pred_call;
      pop = pred_ret;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip <= `RESET_IP;
      fetch_ght <= '0;
      fetch_valid <= 1'b0;
    end else begin
      fetch_ip <= next_ip;
      fetch_ght <= next_ght;
      fetch_valid <= 1'b1;
    end
  end

  // redirect sources must hand over whole blocks
  a_ip_aligned: assert property (@(posedge clk) disable iff (rst)
    fetch_ip[`BLOCK_SHIFT-1:0] == '0);

endmodule

/* rtl/fetch_frontend.sv */
`include "frontend_config.svh"

module fetch_frontend (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  hold,
  input  logic                  irq_valid,
  input  frontend_pkg::addr_t   irq_ip,
  input  logic                  upd_valid,
  input  frontend_pkg::addr_t   upd_src_ip,
  input  frontend_pkg::addr_t   upd_target,
  input  logic                  upd_slot,
  input  frontend_pkg::br_kind_t upd_kind,
  input  logic                  upd_taken,
  input  logic                  upd_mispredict,
  input  frontend_pkg::ght_t    upd_ght,
  output frontend_pkg::addr_t   fetch_ip,
  output frontend_pkg::ght_t    fetch_ght,
  output logic                  fetch_valid
);

  frontend_pkg::slot_bits_t hit;
  frontend_pkg::slot_bits_t pred;
  frontend_pkg::addr_t      target0;
  frontend_pkg::addr_t      target1;
  frontend_pkg::br_kind_t   kind0;
  frontend_pkg::br_kind_t   kind1;
  frontend_pkg::addr_t      ras_top;
  frontend_pkg::addr_t      push_addr;
  logic                     push;
  logic                     pop;

  fetch_sequencer u_seq (
    .clk, .rst, .hold,
    .irq_valid, .irq_ip,
    .upd_valid, .upd_src_ip, .upd_target, .upd_taken, .upd_mispredict, .upd_ght,
    .hit, .pred, .target0, .target1, .kind0, .kind1, .ras_top,
    .fetch_ip, .fetch_ght, .fetch_valid,
    .push, .push_addr, .pop
  );

  branch_target_buffer u_btb (
    .clk, .rst, .fetch_ip,
    .upd_valid, .upd_src_ip, .upd_slot, .upd_target, .upd_kind,
    .hit, .target0, .target1, .kind0, .kind1
  );

  hashed_predictor u_pred (
    .clk, .rst, .fetch_ip, .fetch_ght,
    .upd_valid, .upd_mispredict, .upd_src_ip, .upd_ght, .upd_slot,
    .pred
  );

  return_stack u_ras (
    .clk, .rst,
    .push, .push_addr, .pop,
    .ras_top
  );

endmodule

/* verification/tb_fetch_frontend.sv */
`include "frontend_config.svh"

module tb_fetch_frontend;

  timeunit 1ns;
  timeprecision 100ps;

  localparam string DATA_FILE = "verification/fetch_frontend_testdata.txt";
  localparam int RESET_CYCLES = 10;
  localparam int TIMEOUT_MARGIN = 50;

  // one row of the data file
  typedef struct packed {
    logic                   hold;
    logic                   irq_valid;
    frontend_pkg::addr_t    irq_ip;
    logic                   upd_valid;
    frontend_pkg::addr_t    upd_src_ip;
    frontend_pkg::addr_t    upd_target;
    logic                   upd_slot;
    frontend_pkg::br_kind_t upd_kind;
    logic                   upd_taken;
    logic                   upd_mispredict;
    frontend_pkg::ght_t     upd_ght;
    logic                   chk;
    frontend_pkg::addr_t    exp_ip;
    frontend_pkg::ght_t     exp_ght;
  } vec_t;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   hold;
  logic                   irq_valid;
  frontend_pkg::addr_t    irq_ip;
  logic                   upd_valid;
  frontend_pkg::addr_t    upd_src_ip;
  frontend_pkg::addr_t    upd_target;
  logic                   upd_slot;
  frontend_pkg::br_kind_t upd_kind;
  logic                   upd_taken;
  logic                   upd_mispredict;
  frontend_pkg::ght_t     upd_ght;
  frontend_pkg::addr_t    fetch_ip;
  frontend_pkg::ght_t     fetch_ght;
  logic                   fetch_valid;

  vec_t vectors [$];
  int   cycle_count = 0;
  int   cycle_limit = TIMEOUT_MARGIN; // raised once the rows are loaded

  fetch_frontend dut_i (
    .clk, .rst, .hold,
    .irq_valid, .irq_ip,
    .upd_valid, .upd_src_ip, .upd_target, .upd_slot, .upd_kind,
    .upd_taken, .upd_mispredict, .upd_ght,
    .fetch_ip, .fetch_ght, .fetch_valid
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
      $display("RESULT: FAIL");
      $fatal(1, "simulation ran past its cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] col [14];
    vec_t        v;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("could not open the test data file %s", DATA_FILE);
      $display("RESULT: FAIL");
      $fatal(1, "missing test data");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[0] != "#") begin // skip column notes
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                    col[7], col[8], col[9], col[10], col[11], col[12], col[13]);
        if (n == 14) begin
          v.hold = col[0][0];
          v.irq_valid = col[1][0];
          v.irq_ip = col[2];
          v.upd_valid = col[3][0];
          v.upd_src_ip = col[4];
          v.upd_target = col[5];
          v.upd_slot = col[6][0];
          v.upd_kind = col[7][1:0];
          v.upd_taken = col[8][0];
          v.upd_mispredict = col[9][0];
          v.upd_ght = col[10][7:0];
          v.chk = col[11][0];
          v.exp_ip = col[12];
          v.exp_ght = col[13][7:0];
          vectors.push_back(v);
        end else if (n > 0) begin
          $display("the test data file has a row with missing columns: %s", line);
          $display("RESULT: FAIL");
          $fatal(1, "bad test data row");
        end
      end
    end
    $fclose(fd);
    if (vectors.size() == 0) begin
      $display("the test data file holds no rows");
      $display("RESULT: FAIL");
      $fatal(1, "empty test data");
    end
    cycle_limit = vectors.size() + TIMEOUT_MARGIN;
  endtask

  task automatic apply_vector(input vec_t v);
    hold = v.hold;
    irq_valid = v.irq_valid;
    irq_ip = v.irq_ip;
    upd_valid = v.upd_valid;
    upd_src_ip = v.upd_src_ip;
    upd_target = v.upd_target;
    upd_slot = v.upd_slot;
    upd_kind = v.upd_kind;
    upd_taken = v.upd_taken;
    upd_mispredict = v.upd_mispredict;
    upd_ght = v.upd_ght;
  endtask

  initial begin
    rst = 1'b1;
    hold = 1'b0;
    irq_valid = 1'b0;
    irq_ip = '0;
    upd_valid = 1'b0;
    upd_src_ip = '0;
    upd_target = '0;
    upd_slot = 1'b0;
    upd_kind = '0;
    upd_taken = 1'b0;
    upd_mispredict = 1'b0;
    upd_ght = '0;
    load_vectors();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    check_value("fetch_valid", 32'(fetch_valid), 32'd0);
    check_value("fetch_ip", fetch_ip, `RESET_IP);
    check_value("fetch_ght", 32'(fetch_ght), 32'd0);
    rst = 1'b0;

    // drive on the falling edge, look at the result one falling edge later
    foreach (vectors[i]) begin
      apply_vector(vectors[i]);
      @(posedge clk);
      @(negedge clk);
      if (vectors[i].chk) begin
        check_value("fetch_valid", 32'(fetch_valid), 32'd1);
        check_value("fetch_ip", fetch_ip, vectors[i].exp_ip);
        check_value("fetch_ght", 32'(fetch_ght), 32'(vectors[i].exp_ght));
      end
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* verification/fetch_frontend_testdata.txt */
# hold irq_valid irq_ip upd_valid upd_src_ip upd_target upd_slot upd_kind upd_taken
# upd_mispredict upd_ght chk exp_fetch_ip exp_fetch_ght (all hex, one row per cycle)
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00001000 00
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00001020 00
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00001040 00
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00001060 00
1 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00001060 00
1 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00001060 00
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00001080 00
0 0 00000000 1 00001100 00002000 0 1 1 0 00 1 000010a0 00
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 000010c0 00
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 000010e0 00
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00001100 00
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00002000 01
0 0 00000000 1 00002040 00003000 0 0 0 0 00 1 00002020 01
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00002040 01
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00002060 02
0 0 00000000 1 00002040 00003000 0 0 1 1 01 1 00003000 03
0 0 00000000 1 00003000 00002040 1 1 1 1 00 1 00002040 01
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00003000 03
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00002040 07
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00002060 0e
0 0 00000000 1 000020c0 00004000 0 1 1 0 00 1 00002080 0e
0 0 00000000 1 00004000 00005080 0 2 1 0 00 1 000020a0 0e
0 0 00000000 1 00005080 00006000 0 0 0 0 00 1 000020c0 0e
0 0 00000000 1 00005080 00000000 1 3 1 0 00 1 00004000 1d
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00005080 3b
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00004020 ed
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00004040 ed
0 1 00005080 0 00000000 00000000 0 0 0 0 00 1 00005080 ed
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00004040 b5
0 1 00007000 1 00006000 00006100 0 0 0 1 55 1 00006020 aa
1 1 00007000 0 00000000 00000000 0 0 0 0 00 1 00007000 aa
1 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00007000 aa
0 0 00000000 0 00000000 00000000 0 0 0 0 00 1 00007020 aa

/* all.f */
+incdir+common
common/frontend_pkg.sv
predict/branch_target_buffer.sv
predict/hashed_predictor.sv
predict/return_stack.sv
rtl/fetch_sequencer.sv
rtl/fetch_frontend.sv
verification/tb_fetch_frontend.sv

/* Makefile */
# Verilator build and run for the fetch front end

VERILATOR  ?= verilator
TOP        ?= tb_fetch_frontend
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
